//--- source/core_mem_macros.svh
`ifndef CORE_MEM_MACROS_SVH
`define CORE_MEM_MACROS_SVH

// fetch starts here after reset
`define PC_INIT 32'h0000_0000

// l1 instruction cache geometry
`define L1I_LINES      4
`define L1I_LINE_WORDS 2
`define L1I_IDX_W      ($clog2(`L1I_LINES))
`define L1I_OFF_W      ($clog2(`L1I_LINE_WORDS))
// 2 bits of byte offset below the word offset
`define L1I_TAG_W      (32 - `L1I_IDX_W - `L1I_OFF_W - 2)

// unified memory, in words
`define MEM_DEPTH 256
`define MEM_AW    ($clog2(`MEM_DEPTH))

// rv32 opcodes that end a fetch run
`define OP_JAL    7'b110_1111
`define OP_JALR   7'b110_0111
`define OP_BRANCH 7'b110_0011
`define OP_SYSTEM 7'b111_0011

`define INST_FENCE_I 32'h0000_100F

`endif

//--- source/core_mem_pkg.sv
package fetch_mem_pkg;

  // one single-word memory transaction
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // read data returned with ack
  typedef struct packed {
    logic [31:0] rdata;
  } mem_rsp_t;

  // item handed to decode
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_out_t;

  // from execute, after a control-flow instruction
  // taken loads target, skip goes on at pc+4
  typedef struct packed {
    logic        taken;
    logic        skip;
    logic [31:0] target;
  } redirect_t;

endpackage

//--- source/ifu_icache.sv
`include "core_mem_macros.svh"

module ifu_icache (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_en_i,
  input  logic                      redirect_valid_i,
  input  fetch_mem_pkg::redirect_t  redirect_i,
  output logic                      fetch_valid_o,
  input  logic                      fetch_ready_i,
  output fetch_mem_pkg::fetch_out_t fetch_o,
  output logic                      mem_req_o,
  output fetch_mem_pkg::mem_req_t   mem_req_data_o,
  input  logic                      mem_ack_i,
  input  fetch_mem_pkg::mem_rsp_t   mem_rsp_i
);

  // line fill, one word per four-phase transaction
  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_ACK0,
    FILL_REQ1,
    FILL_ACK1
  } fill_state_e;

  fill_state_e fill_state_q;

  logic [31:0] pc_q;
  logic        stall_q;
  logic        req_q;
  logic [31:0] req_addr_q;

  logic [31:0]           line_data_q  [`L1I_LINES][`L1I_LINE_WORDS];
  logic [`L1I_TAG_W-1:0] line_tag_q   [`L1I_LINES];
  logic [`L1I_LINES-1:0] line_valid_q;

  logic [`L1I_TAG_W-1:0] pc_tag;
  logic [`L1I_IDX_W-1:0] pc_idx;
  logic [`L1I_OFF_W-1:0] pc_off;
  logic [31:0]           line_base;
  logic [31:0]           inst;
  logic [6:0]            opcode;
  logic                  hit;
  logic                  need_fill;
  logic                  xfer;
  logic                  is_ctrl;
  logic                  is_fence_i;

  assign pc_tag    = pc_q[31 -: `L1I_TAG_W];
  assign pc_idx    = pc_q[`L1I_IDX_W + `L1I_OFF_W + 1 -: `L1I_IDX_W];
  assign pc_off    = pc_q[`L1I_OFF_W + 1 -: `L1I_OFF_W];
  assign line_base = {pc_q[31:`L1I_OFF_W + 2], {(`L1I_OFF_W + 2){1'b0}}};

  assign hit = (fill_state_q == FILL_IDLE) && line_valid_q[pc_idx] &&
               (line_tag_q[pc_idx] == pc_tag);

  // no fetching past an unresolved control-flow instruction
  assign need_fill = fetch_en_i && !stall_q && !hit;

  assign inst   = line_data_q[pc_idx][pc_off];
  assign opcode = inst[6:0];

  assign is_ctrl = (opcode == `OP_JAL) || (opcode == `OP_JALR) ||
                   (opcode == `OP_BRANCH) || (opcode == `OP_SYSTEM);
  assign is_fence_i = (inst == `INST_FENCE_I);

  assign fetch_valid_o = fetch_en_i && hit && !stall_q;
  assign fetch_o.pc    = pc_q;
  assign fetch_o.inst  = inst;

  assign xfer = fetch_valid_o && fetch_ready_i;

  assign mem_req_o            = req_q;
  assign mem_req_data_o.we    = 1'b0;
  assign mem_req_data_o.addr  = req_addr_q;
  assign mem_req_data_o.wdata = '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_state_q <= FILL_IDLE;
      req_q        <= 1'b0;
      pc_q         <= `PC_INIT;
      stall_q      <= 1'b0;
      line_valid_q <= '0;
    end else begin
      case (fill_state_q)
        FILL_IDLE: begin
          // previous ack must be gone before a new req
          if (need_fill && !mem_ack_i) begin
            req_q        <= 1'b1;
            fill_state_q <= FILL_ACK0;
          end
        end
        FILL_ACK0: begin
          if (mem_ack_i) begin
            req_q        <= 1'b0;
            fill_state_q <= FILL_REQ1;
          end
        end
        FILL_REQ1: begin
          if (!mem_ack_i) begin
            req_q        <= 1'b1;
            fill_state_q <= FILL_ACK1;
          end
        end
        FILL_ACK1: begin
          if (mem_ack_i) begin
            req_q                <= 1'b0;
            line_valid_q[pc_idx] <= 1'b1;
            fill_state_q         <= FILL_IDLE;
          end
        end
        default: fill_state_q <= FILL_IDLE;
      endcase

      if (xfer) begin
        if (is_fence_i) begin
          line_valid_q <= '0;
          pc_q         <= pc_q + 32'd4;
        end else if (is_ctrl) begin
          stall_q <= 1'b1;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end else if (stall_q && redirect_valid_i &&
                   (redirect_i.taken || redirect_i.skip)) begin
        stall_q <= 1'b0;
        if (redirect_i.taken) begin
          pc_q <= redirect_i.target;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

  // cache contents and bus address
  always_ff @(posedge clk) begin
    case (fill_state_q)
      FILL_IDLE: req_addr_q <= line_base;
      FILL_ACK0: begin
        if (mem_ack_i) begin
          line_data_q[pc_idx][0] <= mem_rsp_i.rdata;
          req_addr_q             <= line_base + 32'd4;
        end
      end
      FILL_ACK1: begin
        if (mem_ack_i) begin
          line_data_q[pc_idx][1] <= mem_rsp_i.rdata;
          line_tag_q[pc_idx]     <= pc_tag;
        end
      end
      default: ;
    endcase
  end

endmodule

//--- source/lsu_port.sv
module lsu_port (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    lsu_req_i,
  input  fetch_mem_pkg::mem_req_t lsu_req_data_i,
  output logic                    lsu_ack_o,
  output fetch_mem_pkg::mem_rsp_t lsu_rsp_o,
  output logic                    mem_req_o,
  output fetch_mem_pkg::mem_req_t mem_req_data_o,
  input  logic                    mem_ack_i,
  input  fetch_mem_pkg::mem_rsp_t mem_rsp_i
);

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_BUS,
    LSU_CLOSE
  } lsu_state_e;

  lsu_state_e              state_q;
  logic                    mem_req_q;
  logic                    lsu_ack_q;
  fetch_mem_pkg::mem_req_t req_data_q;
  fetch_mem_pkg::mem_rsp_t rsp_q;

  assign mem_req_o      = mem_req_q;
  assign mem_req_data_o = req_data_q;
  assign lsu_ack_o      = lsu_ack_q;
  assign lsu_rsp_o      = rsp_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= LSU_IDLE;
      mem_req_q <= 1'b0;
      lsu_ack_q <= 1'b0;
    end else begin
      case (state_q)
        LSU_IDLE: begin
          if (lsu_req_i) begin
            mem_req_q <= 1'b1;
            state_q   <= LSU_BUS;
          end
        end
        LSU_BUS: begin
          if (mem_ack_i) begin
            mem_req_q <= 1'b0;
            lsu_ack_q <= 1'b1;
            state_q   <= LSU_CLOSE;
          end
        end
        LSU_CLOSE: begin
          if (!lsu_req_i) begin
            lsu_ack_q <= 1'b0;
          end
          // both sides closed, or outside already started the next one
          if (!mem_ack_i && (!lsu_req_i || !lsu_ack_q)) begin
            state_q <= LSU_IDLE;
          end
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == LSU_IDLE && lsu_req_i) begin
      req_data_q <= lsu_req_data_i;
    end
    if (state_q == LSU_BUS && mem_ack_i) begin
      rsp_q <= mem_rsp_i;
    end
  end

endmodule

//--- source/bus_arbiter.sv
module bus_arbiter #(
  parameter type req_t = fetch_mem_pkg::mem_req_t
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [1:0]              req_i,
  input  req_t                    req_data_i [2],
  output logic [1:0]              ack_o,
  output fetch_mem_pkg::mem_rsp_t rsp_o,
  output logic                    mem_req_o,
  output req_t                    mem_req_data_o,
  input  logic                    mem_ack_i,
  input  fetch_mem_pkg::mem_rsp_t mem_rsp_i
);

  logic busy_q;
  logic grant_q;
  logic last_q;
  logic mem_req_q;
  req_t mem_req_data_q;
  logic winner;

  // on a tie the loser of the previous round goes first
  always_comb begin
    if (req_i == 2'b11) begin
      winner = ~last_q;
    end else begin
      winner = req_i[1];
    end
  end

  assign mem_req_o      = mem_req_q;
  assign mem_req_data_o = mem_req_data_q;

  // ack goes back only to the granted side
  assign ack_o[0] = busy_q && !grant_q && mem_ack_i;
  assign ack_o[1] = busy_q && grant_q && mem_ack_i;
  assign rsp_o    = mem_rsp_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q    <= 1'b0;
      grant_q   <= 1'b0;
      last_q    <= 1'b1;
      mem_req_q <= 1'b0;
    end else if (!busy_q) begin
      if (|req_i) begin
        busy_q    <= 1'b1;
        grant_q   <= winner;
        last_q    <= winner;
        mem_req_q <= 1'b1;
      end
    end else begin
      mem_req_q <= req_i[grant_q];
      // hold the grant until the whole handshake has closed
      if (!req_i[grant_q] && !mem_req_q && !mem_ack_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy_q && (|req_i)) begin
      mem_req_data_q <= req_data_i[winner];
    end
  end

endmodule

//--- source/unified_memory.sv
`include "core_mem_macros.svh"

module unified_memory (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_i,
  input  fetch_mem_pkg::mem_req_t req_data_i,
  output logic                    ack_o,
  output fetch_mem_pkg::mem_rsp_t rsp_o
);

  logic [31:0]         mem_q [`MEM_DEPTH];
  logic [31:0]         rdata_q;
  logic                ack_q;
  logic [`MEM_AW-1:0]  word_addr;
  logic                start;

  // word index from the byte address
  assign word_addr = req_data_i.addr[`MEM_AW + 1:2];

  // new transaction, req seen with ack still low
  assign start = req_i && !ack_q;

  assign ack_o       = ack_q;
  assign rsp_o.rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else if (start) begin
      ack_q <= 1'b1;
    end else if (!req_i && ack_q) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      if (req_data_i.we) begin
        mem_q[word_addr] <= req_data_i.wdata;
      end
      rdata_q <= mem_q[word_addr];
    end
  end

endmodule

//--- source/core_mem_top.sv
module core_mem_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_en_i,
  input  logic                      redirect_valid_i,
  input  fetch_mem_pkg::redirect_t  redirect_i,
  output logic                      fetch_valid_o,
  input  logic                      fetch_ready_i,
  output fetch_mem_pkg::fetch_out_t fetch_o,
  input  logic                      lsu_req_i,
  input  fetch_mem_pkg::mem_req_t   lsu_req_data_i,
  output logic                      lsu_ack_o,
  output fetch_mem_pkg::mem_rsp_t   lsu_rsp_o
);

  logic                    ifu_req;
  fetch_mem_pkg::mem_req_t ifu_req_data;
  logic                    lsu_mem_req;
  fetch_mem_pkg::mem_req_t lsu_mem_req_data;

  logic [1:0]              arb_req;
  fetch_mem_pkg::mem_req_t arb_req_data [2];
  logic [1:0]              arb_ack;
  fetch_mem_pkg::mem_rsp_t arb_rsp;

  logic                    mem_req;
  fetch_mem_pkg::mem_req_t mem_req_data;
  logic                    mem_ack;
  fetch_mem_pkg::mem_rsp_t mem_rsp;

  // port 0 fetch, port 1 load/store
  assign arb_req         = {lsu_mem_req, ifu_req};
  assign arb_req_data[0] = ifu_req_data;
  assign arb_req_data[1] = lsu_mem_req_data;

  ifu_icache ifu_icache_i (
    .clk              (clk),
    .rst              (rst),
    .fetch_en_i       (fetch_en_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_i       (redirect_i),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_ready_i    (fetch_ready_i),
    .fetch_o          (fetch_o),
    .mem_req_o        (ifu_req),
    .mem_req_data_o   (ifu_req_data),
    .mem_ack_i        (arb_ack[0]),
    .mem_rsp_i        (arb_rsp)
  );

  lsu_port lsu_port_i (
    .clk            (clk),
    .rst            (rst),
    .lsu_req_i      (lsu_req_i),
    .lsu_req_data_i (lsu_req_data_i),
    .lsu_ack_o      (lsu_ack_o),
    .lsu_rsp_o      (lsu_rsp_o),
    .mem_req_o      (lsu_mem_req),
    .mem_req_data_o (lsu_mem_req_data),
    .mem_ack_i      (arb_ack[1]),
    .mem_rsp_i      (arb_rsp)
  );

  bus_arbiter #(
    .req_t (fetch_mem_pkg::mem_req_t)
  ) bus_arbiter_i (
    .clk            (clk),
    .rst            (rst),
    .req_i          (arb_req),
    .req_data_i     (arb_req_data),
    .ack_o          (arb_ack),
    .rsp_o          (arb_rsp),
    .mem_req_o      (mem_req),
    .mem_req_data_o (mem_req_data),
    .mem_ack_i      (mem_ack),
    .mem_rsp_i      (mem_rsp)
  );

  unified_memory unified_memory_i (
    .clk        (clk),
    .rst        (rst),
    .req_i      (mem_req),
    .req_data_i (mem_req_data),
    .ack_o      (mem_ack),
    .rsp_o      (mem_rsp)
  );

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a rising edge so the falling-edge stimulus sees a settled reset
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- sim/core_mem_top_tb.sv
`include "core_mem_macros.svh"

module core_mem_top_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD_NS   = 40;
  localparam int N_PROG          = 16;
  localparam int N_STREAM        = 33;
  localparam int N_OPS           = 24;
  localparam int ITEM_LIMIT      = 200;
  localparam int HS_LIMIT        = 200;
  localparam int HOLD_CYCLES     = 3;
  localparam int WATCHDOG_CYCLES = 400 * (N_PROG + N_STREAM);

  localparam logic [31:0] DATA_BASE = 32'h0000_0300;
  localparam logic [31:0] NEW_WORD  = 32'h0090_0493;

  localparam logic [1:0] ACT_NONE  = 2'd0;
  localparam logic [1:0] ACT_TAKEN = 2'd1;
  localparam logic [1:0] ACT_SKIP  = 2'd2;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] inst;
  } prog_t;

  // stall is the chance in percent that ready is low in a cycle
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [1:0]  act;
    logic [31:0] target;
    logic [6:0]  stall;
  } stream_t;

  prog_t prog_tab [N_PROG] = '{
    {32'h0000_0000, 32'h0010_0093},
    {32'h0000_0004, 32'h0020_0113},
    {32'h0000_0008, 32'h0030_0193},
    {32'h0000_000C, 32'h0000_1463},
    {32'h0000_0010, 32'h0040_0213},
    {32'h0000_0014, 32'h02C0_006F},
    {32'h0000_0040, 32'h0050_0293},
    {32'h0000_0044, 32'h0060_0313},
    {32'h0000_0048, 32'h0070_0393},
    {32'h0000_004C, 32'hFE20_9AE3},
    {32'h0000_0050, `INST_FENCE_I},
    {32'h0000_0054, 32'h0002_8067},
    {32'h0000_0060, 32'h0080_0413},
    {32'h0000_0064, 32'h00A0_0513},
    {32'h0000_0068, 32'h0000_0073},
    {32'h0000_006C, 32'h0000_8067}
  };

  stream_t stream_tab [N_STREAM] = '{
    {`PC_INIT,      32'h0010_0093, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0004, 32'h0020_0113, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0008, 32'h0030_0193, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_000C, 32'h0000_1463, ACT_SKIP,  32'h0000_0000, 7'd0},
    {32'h0000_0010, 32'h0040_0213, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0014, 32'h02C0_006F, ACT_TAKEN, 32'h0000_0040, 7'd0},
    // loop, first pass with ready stalls
    {32'h0000_0040, 32'h0050_0293, ACT_NONE,  32'h0000_0000, 7'd50},
    {32'h0000_0044, 32'h0060_0313, ACT_NONE,  32'h0000_0000, 7'd50},
    {32'h0000_0048, 32'h0070_0393, ACT_NONE,  32'h0000_0000, 7'd50},
    {32'h0000_004C, 32'hFE20_9AE3, ACT_TAKEN, 32'h0000_0040, 7'd50},
    {32'h0000_0040, 32'h0050_0293, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0044, 32'h0060_0313, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0048, 32'h0070_0393, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_004C, 32'hFE20_9AE3, ACT_TAKEN, 32'h0000_0040, 7'd0},
    // 0x44 rewritten before this pass, cache still holds the old word
    {32'h0000_0040, 32'h0050_0293, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0044, 32'h0060_0313, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0048, 32'h0070_0393, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_004C, 32'hFE20_9AE3, ACT_SKIP,  32'h0000_0000, 7'd0},
    {32'h0000_0050, `INST_FENCE_I, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0054, 32'h0002_8067, ACT_TAKEN, 32'h0000_0040, 7'd0},
    {32'h0000_0040, 32'h0050_0293, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0044, NEW_WORD,      ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0048, 32'h0070_0393, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_004C, 32'hFE20_9AE3, ACT_SKIP,  32'h0000_0000, 7'd0},
    {32'h0000_0050, `INST_FENCE_I, ACT_NONE,  32'h0000_0000, 7'd0},
    {32'h0000_0054, 32'h0002_8067, ACT_TAKEN, 32'h0000_0060, 7'd0},
    {32'h0000_0060, 32'h0080_0413, ACT_NONE,  32'h0000_0000, 7'd30},
    {32'h0000_0064, 32'h00A0_0513, ACT_NONE,  32'h0000_0000, 7'd30},
    {32'h0000_0068, 32'h0000_0073, ACT_SKIP,  32'h0000_0000, 7'd30},
    {32'h0000_006C, 32'h0000_8067, ACT_TAKEN, 32'h0000_0000, 7'd30},
    {32'h0000_0000, 32'h0010_0093, ACT_NONE,  32'h0000_0000, 7'd30},
    {32'h0000_0004, 32'h0020_0113, ACT_NONE,  32'h0000_0000, 7'd30},
    {32'h0000_0008, 32'h0030_0193, ACT_NONE,  32'h0000_0000, 7'd30}
  };

  logic                      clk;
  logic                      rst;
  logic                      fetch_en_i;
  logic                      redirect_valid_i;
  fetch_mem_pkg::redirect_t  redirect_i;
  logic                      fetch_valid_o;
  logic                      fetch_ready_i;
  fetch_mem_pkg::fetch_out_t fetch_o;
  logic                      lsu_req_i;
  fetch_mem_pkg::mem_req_t   lsu_req_data_i;
  logic                      lsu_ack_o;
  fetch_mem_pkg::mem_rsp_t   lsu_rsp_o;

  logic [2:0]  op_slot [N_OPS];
  logic        op_we   [N_OPS];
  logic [31:0] op_data [N_OPS];
  logic [31:0] shadow  [8];

  int error_count  = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (10)
  ) clock_gen_i (
    .clk_o (clk),
    .rst_o (rst)
  );

  core_mem_top core_mem_top_i (
    .clk              (clk),
    .rst              (rst),
    .fetch_en_i       (fetch_en_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_i       (redirect_i),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_ready_i    (fetch_ready_i),
    .fetch_o          (fetch_o),
    .lsu_req_i        (lsu_req_i),
    .lsu_req_data_i   (lsu_req_data_i),
    .lsu_ack_o        (lsu_ack_o),
    .lsu_rsp_o        (lsu_rsp_o)
  );

  function automatic logic [31:0] prog_word(input logic [31:0] addr);
    logic [31:0] word;
    word = '0;
    for (int k = 0; k < N_PROG; k++) begin
      if (prog_tab[k].addr == addr) begin
        word = prog_tab[k].inst;
      end
    end
    return word;
  endfunction

  task automatic expect_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] at %0d ns: %s gave %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic close_test(input string name, input int errs_at_start);
    if (error_count == errs_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - errs_at_start);
    end
  endtask

  // one four-phase transaction on the external load/store link
  task automatic lsu_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int guard;
    @(negedge clk);
    lsu_req_data_i.we    = we;
    lsu_req_data_i.addr  = addr;
    lsu_req_data_i.wdata = wdata;
    lsu_req_i            = 1'b1;
    guard = 0;
    while (!lsu_ack_o && guard < HS_LIMIT) begin
      @(negedge clk);
      guard++;
    end
    if (!lsu_ack_o) begin
      $display("load/store port never acknowledged the access to %h", addr);
      error_count++;
    end
    rdata     = lsu_rsp_o.rdata;
    lsu_req_i = 1'b0;
    guard = 0;
    while (lsu_ack_o && guard < HS_LIMIT) begin
      @(negedge clk);
      guard++;
    end
    if (lsu_ack_o) begin
      $display("load/store port kept ack high after the request dropped");
      error_count++;
    end
  endtask

  // decode and execute model over a slice of the stream table
  task automatic run_stream(input int first, input int last, output int max_wait);
    stream_t e;
    int      idx;
    int      waited;
    int      guard;
    logic    r;
    logic    got_item;
    max_wait = 0;
    for (idx = first; idx <= last; idx++) begin
      e        = stream_tab[idx];
      waited   = 0;
      guard    = 0;
      got_item = 1'b0;
      while (!got_item && guard < ITEM_LIMIT) begin
        @(negedge clk);
        r = (($urandom % 100) >= e.stall);
        fetch_ready_i = r;
        if (fetch_valid_o && r) begin
          got_item = 1'b1;
        end else if (!fetch_valid_o) begin
          waited++;
        end
        guard++;
      end
      if (!got_item) begin
        $display("stream ended early: no item for entry %0d at pc %h", idx, e.pc);
        error_count++;
        fetch_ready_i = 1'b0;
        return;
      end
      if (waited > max_wait) begin
        max_wait = waited;
      end
      if (fetch_o.pc !== e.pc) begin
        $display("[FAIL] at %0d ns: entry %0d pc %h, expected %h",
                 $time, idx, fetch_o.pc, e.pc);
        error_count++;
      end
      if (fetch_o.inst !== e.inst) begin
        $display("[FAIL] at %0d ns: entry %0d inst %h, expected %h",
                 $time, idx, fetch_o.inst, e.inst);
        error_count++;
      end
      if (e.act != ACT_NONE) begin
        // ready stays high so a leaked item would really transfer
        repeat (HOLD_CYCLES) begin
          @(negedge clk);
          fetch_ready_i = 1'b1;
          if (fetch_valid_o) begin
            $display("[FAIL] at %0d ns: item at pc %h offered before the redirect",
                     $time, fetch_o.pc);
            error_count++;
          end
        end
        @(negedge clk);
        fetch_ready_i     = 1'b0;
        redirect_i.taken  = (e.act == ACT_TAKEN);
        redirect_i.skip   = (e.act == ACT_SKIP);
        redirect_i.target = e.target;
        redirect_valid_i  = 1'b1;
        @(negedge clk);
        redirect_valid_i = 1'b0;
      end
    end
    @(negedge clk);
    fetch_ready_i = 1'b0;
  endtask

  task automatic lsu_random_traffic();
    logic [31:0] rd;
    logic [31:0] addr;
    int          k;
    for (k = 0; k < N_OPS; k++) begin
      addr = DATA_BASE + {27'd0, op_slot[k], 2'b00};
      if (op_we[k]) begin
        lsu_access(1'b1, addr, op_data[k], rd);
        shadow[op_slot[k]] = op_data[k];
      end else begin
        lsu_access(1'b0, addr, 32'h0, rd);
        expect_word("random load", rd, shadow[op_slot[k]]);
      end
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("watchdog: run still going after %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int          mark;
    int          max_wait;
    int          k;
    logic [31:0] rd;

    fetch_en_i       = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_i       = '0;
    fetch_ready_i    = 1'b0;
    lsu_req_i        = 1'b0;
    lsu_req_data_i   = '0;

    void'($urandom(73));
    // the first 8 ops cover every slot with a write
    for (k = 0; k < N_OPS; k++) begin
      op_slot[k] = (k < 8) ? 3'(k) : 3'($urandom % 8);
      op_we[k]   = (k < 8) ? 1'b1 : 1'($urandom % 2);
      op_data[k] = $urandom;
    end

    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end

    // boot: fetch held at its reset pc while the program goes in
    mark = error_count;
    for (k = 0; k < N_PROG; k++) begin
      lsu_access(1'b1, prog_tab[k].addr, prog_tab[k].inst, rd);
    end
    close_test("program load", mark);

    mark = error_count;
    lsu_access(1'b1, 32'h0000_03F0, 32'hA5C3_1E07, rd);
    lsu_access(1'b0, 32'h0000_03F0, 32'h0, rd);
    expect_word("read after write", rd, 32'hA5C3_1E07);
    lsu_access(1'b0, 32'h0000_0048, 32'h0, rd);
    expect_word("program word read", rd, prog_word(32'h0000_0048));
    close_test("load/store write and read", mark);

    @(negedge clk);
    fetch_en_i = 1'b1;

    mark = error_count;
    run_stream(0, 2, max_wait);
    close_test("fetch in order", mark);

    mark = error_count;
    run_stream(3, 5, max_wait);
    close_test("control flow stall", mark);

    mark = error_count;
    run_stream(6, 9, max_wait);
    close_test("loop with ready stalls", mark);

    mark = error_count;
    run_stream(10, 13, max_wait);
    if (max_wait > 1) begin
      $display("[FAIL] at %0d ns: second loop pass waited %0d cycles, not a hit",
               $time, max_wait);
      error_count++;
    end
    close_test("loop from cache", mark);

    mark = error_count;
    lsu_access(1'b1, 32'h0000_0044, NEW_WORD, rd);
    run_stream(14, 19, max_wait);
    close_test("stale word until fence.i", mark);

    mark = error_count;
    run_stream(20, 25, max_wait);
    close_test("new word after fence.i", mark);

    mark = error_count;
    fork
      run_stream(26, 32, max_wait);
      lsu_random_traffic();
    join
    close_test("load/store traffic during fetch", mark);

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- core_mem_top.f
+incdir+source
source/core_mem_pkg.sv
source/ifu_icache.sv
source/lsu_port.sv
source/bus_arbiter.sv
source/unified_memory.sv
source/core_mem_top.sv
sim/tb_clock_gen.sv
sim/core_mem_top_tb.sv

//--- Bender.yml
package:
  name: core_mem

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/core_mem_pkg.sv
      - source/ifu_icache.sv
      - source/lsu_port.sv
      - source/bus_arbiter.sv
      - source/unified_memory.sv
      - source/core_mem_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_clock_gen.sv
      - sim/core_mem_top_tb.sv
